/* design/busMaster.sv */
`timescale 1ns/1ps

module busMaster import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input memReqT req,
	input addrT memAddr,
	input dataT storeData,
	output logic done,
	output dataT readData,
	output addrT wbAdr,
	output dataT wbDatOut,
	input dataT wbDatIn,
	output logic wbWe,
	output logic wbCyc,
	output logic wbStb,
	input logic wbAck
);

	logic busy;
	logic start;
	logic ackSeen;

	// no new cycle while one runs or while done is still up
	assign start = req.valid && !busy && !done;
	assign ackSeen = busy && wbAck;

	assign wbCyc = busy;
	assign wbStb = busy;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			busy <= 1'b0;
			wbWe <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= ackSeen;
			if (start) begin
				busy <= 1'b1;
				wbWe <= req.write;
			end else if (ackSeen) begin
				busy <= 1'b0;
				wbWe <= 1'b0;
			end
		end
	end

	// address and write data held until ack
	always_ff @(posedge clk) begin
		if (start) begin
			wbAdr <= memAddr;
			wbDatOut <= req.wdataFromAc ? storeData : '0;
		end
		if (ackSeen && !wbWe) begin
			readData <= wbDatIn;
		end
	end

endmodule

/* design/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input opcodeT opcode,
	input logic zero,
	input logic done,
	output ctrlWordT ctrl,
	output memReqT req,
	output logic halted
);

	stateT state;
	stateT nextState;

	function automatic memReqT readReq(addrSelT sel);
		memReqT r;
		r = '0;
		r.valid = 1'b1;
		r.addrSel = sel;
		return r;
	endfunction

	function automatic memReqT writeReq(addrSelT sel);
		memReqT r;
		r = '0;
		r.valid = 1'b1;
		r.write = 1'b1;
		r.addrSel = sel;
		r.wdataFromAc = 1'b1;
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stFetch;
		end else begin
			state <= nextState;
		end
	end

	assign halted = (state == stHalt);

	always_comb begin
		nextState = state;
		ctrl = '0;
		req = '0;
		case (state)
			stFetch: begin
				req = readReq(addrPc);
				if (done) begin
					nextState = stFetchWr;
				end
			end
			stFetchWr: begin
				ctrl.busSel = busMem;
				ctrl.wrtEn.ir = 1'b1;
				ctrl.incEn.pc = 1'b1;
				nextState = stExec;
			end
			stExec: begin
				// unknown opcodes fall back to fetch
				nextState = stFetch;
				case (opcode)
					ENDOP: nextState = stHalt;
					RSTALL: begin
						ctrl.rstEn.ac = 1'b1;
						ctrl.rstEn.addr = 1'b1;
						ctrl.rstEn.stp = 1'b1;
					end
					RSTAC: ctrl.rstEn.ac = 1'b1;
					RSTADDR: ctrl.rstEn.addr = 1'b1;
					INCAC: ctrl.incEn.ac = 1'b1;
					INCADDR: ctrl.incEn.addr = 1'b1;
					INCSTP: ctrl.incEn.stp = 1'b1;
					ADD: begin
						ctrl.busSel = busAdd;
						ctrl.wrtEn.ac = 1'b1;
					end
					MADDR: begin
						ctrl.busSel = busAc;
						ctrl.wrtEn.addr = 1'b1;
					end
					MSTP: begin
						ctrl.busSel = busAc;
						ctrl.wrtEn.stp = 1'b1;
					end
					MSTPAC: begin
						ctrl.busSel = busStp;
						ctrl.wrtEn.ac = 1'b1;
					end
					LDADDR: begin
						req = readReq(addrPc);
						nextState = stLdAddrReq;
					end
					LDAC: begin
						req = readReq(addrAddr);
						nextState = stLdAcReq;
					end
					STAC: begin
						req = writeReq(addrStp);
						nextState = stStAcReq;
					end
					JMPZ: begin
						if (zero) begin
							req = readReq(addrPc);
							nextState = stJmpReq;
						end else begin
							// skip the target byte
							ctrl.incEn.pc = 1'b1;
						end
					end
					default: ;
				endcase
			end
			stLdAddrReq: begin
				req = readReq(addrPc);
				if (done) begin
					nextState = stLdAddrWr;
				end
			end
			stLdAddrWr: begin
				ctrl.busSel = busMem;
				ctrl.wrtEn.addr = 1'b1;
				ctrl.incEn.pc = 1'b1;
				nextState = stFetch;
			end
			stLdAcReq: begin
				req = readReq(addrAddr);
				if (done) begin
					nextState = stLdAcWr;
				end
			end
			stLdAcWr: begin
				ctrl.busSel = busMem;
				ctrl.wrtEn.ac = 1'b1;
				nextState = stFetch;
			end
			stStAcReq: begin
				req = writeReq(addrStp);
				if (done) begin
					nextState = stFetch;
				end
			end
			stJmpReq: begin
				req = readReq(addrPc);
				if (done) begin
					nextState = stJmpWr;
				end
			end
			stJmpWr: begin
				ctrl.busSel = busMem;
				ctrl.wrtEn.pc = 1'b1;
				nextState = stFetch;
			end
			stHalt: ;
			default: nextState = stFetch;
		endcase
		// address mux follows the request
		ctrl.addrSel = req.addrSel;
	end

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

	localparam int dataWidth = 8;
	localparam int addrWidth = 8;

	typedef logic [dataWidth-1:0] dataT;
	typedef logic [addrWidth-1:0] addrT;

	// instruction set, one byte per opcode
	typedef enum logic [7:0] {
		ENDOP   = 8'h00,
		RSTALL  = 8'h01,
		RSTAC   = 8'h02,
		RSTADDR = 8'h03,
		INCAC   = 8'h04,
		INCADDR = 8'h05,
		INCSTP  = 8'h06,
		LDADDR  = 8'h07,
		LDAC    = 8'h08,
		ADD     = 8'h09,
		MADDR   = 8'h0A,
		MSTP    = 8'h0B,
		MSTPAC  = 8'h0C,
		STAC    = 8'h0D,
		JMPZ    = 8'h0E
	} opcodeT;

	// micro-steps of the sequencer
	typedef enum logic [3:0] {
		stFetch,
		stFetchWr,
		stExec,
		stLdAddrReq,
		stLdAddrWr,
		stLdAcReq,
		stLdAcWr,
		stStAcReq,
		stJmpReq,
		stJmpWr,
		stHalt
	} stateT;

	// one enable bit per named register
	typedef struct packed {
		logic pc;
		logic ir;
		logic ac;
		logic addr;
		logic stp;
	} regMaskT;

	typedef enum logic [1:0] {
		busAc,
		busStp,
		busMem,
		busAdd
	} busSelT;

	typedef enum logic [1:0] {
		addrPc,
		addrAddr,
		addrStp
	} addrSelT;

	typedef struct packed {
		logic valid;
		logic write;
		addrSelT addrSel;
		logic wdataFromAc;
	} memReqT;

	typedef struct packed {
		busSelT busSel;
		addrSelT addrSel;
		regMaskT wrtEn;
		regMaskT incEn;
		regMaskT rstEn;
	} ctrlWordT;

endpackage

/* design/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	output addrT wbAdr,
	output dataT wbDatOut,
	input dataT wbDatIn,
	output logic wbWe,
	output logic wbCyc,
	output logic wbStb,
	input logic wbAck,
	output logic halted
);

	ctrlWordT ctrl;
	memReqT req;
	opcodeT opcode;
	logic zero;
	logic done;
	dataT readData;
	addrT memAddr;
	dataT storeData;

	controlSequencer uSeq (
		.clk(clk),
		.rstN(rstN),
		.opcode(opcode),
		.zero(zero),
		.done(done),
		.ctrl(ctrl),
		.req(req),
		.halted(halted)
	);

	datapath uDp (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.readData(readData),
		.memAddr(memAddr),
		.storeData(storeData),
		.opcode(opcode),
		.zero(zero)
	);

	// fetch and data traffic share one master
	busMaster uBus (
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.memAddr(memAddr),
		.storeData(storeData),
		.done(done),
		.readData(readData),
		.wbAdr(wbAdr),
		.wbDatOut(wbDatOut),
		.wbDatIn(wbDatIn),
		.wbWe(wbWe),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAck(wbAck)
	);

endmodule

/* design/datapath.sv */
`timescale 1ns/1ps

module datapath import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input ctrlWordT ctrl,
	input dataT readData,
	output addrT memAddr,
	output dataT storeData,
	output opcodeT opcode,
	output logic zero
);

	dataT pc;
	dataT ir;
	dataT ac;
	dataT addr;
	dataT stp;
	dataT busVal;
	dataT sum;

	// reset beats write, write beats increment
	function automatic dataT nextVal(
		dataT cur,
		dataT bus,
		logic rst,
		logic wrt,
		logic inc
	);
		if (rst) begin
			return '0;
		end else if (wrt) begin
			return bus;
		end else if (inc) begin
			return cur + 1'b1;
		end
		return cur;
	endfunction

	assign sum = ac + addr;

	always_comb begin
		case (ctrl.busSel)
			busAc: busVal = ac;
			busStp: busVal = stp;
			busMem: busVal = readData;
			default: busVal = sum;
		endcase
	end

	always_comb begin
		case (ctrl.addrSel)
			addrAddr: memAddr = addr;
			addrStp: memAddr = stp;
			default: memAddr = pc;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			ac <= '0;
			addr <= '0;
			stp <= '0;
		end else begin
			pc <= nextVal(pc, busVal, ctrl.rstEn.pc, ctrl.wrtEn.pc, ctrl.incEn.pc);
			ir <= nextVal(ir, busVal, ctrl.rstEn.ir, ctrl.wrtEn.ir, ctrl.incEn.ir);
			ac <= nextVal(ac, busVal, ctrl.rstEn.ac, ctrl.wrtEn.ac, ctrl.incEn.ac);
			addr <= nextVal(addr, busVal, ctrl.rstEn.addr, ctrl.wrtEn.addr,
				ctrl.incEn.addr);
			stp <= nextVal(stp, busVal, ctrl.rstEn.stp, ctrl.wrtEn.stp, ctrl.incEn.stp);
		end
	end

	assign storeData = ac;
	assign opcode = opcodeT'(ir);
	assign zero = (ac == '0);

endmodule

/* filelist.f */
design/cpuPkg.sv
design/busMaster.sv
design/controlSequencer.sv
design/datapath.sv
design/cpuTop.sv
sim/cpuBus_checker.sv
sim/tbCpu.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator; pass is decided from the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tbCpu -f filelist.f -o simCpu

./obj_dir/simCpu +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST PASSED" sim.log; then
	exit 0
fi
exit 1

/* sim/cpuBus_checker.sv */
`timescale 1ns/1ps

module cpuBusChecker import cpuPkg::*; (
	input logic clk,
	input logic rstN,
	input addrT wbAdr,
	input dataT wbDatOut,
	input logic wbWe,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic halted
);

	int failCount = 0;

	// cycle ends right after the slave answers
	assert property (@(posedge clk) disable iff (!rstN) (wbCyc && wbAck) |=> !wbCyc)
		else begin
			failCount++;
			$error("wbCyc still high in the cycle after ack");
		end

	// request held until the slave answers
	assert property (@(posedge clk) disable iff (!rstN)
		(wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut)))
		else begin
			failCount++;
			$error("address, we or data changed during a wait state");
		end

	assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
		else begin
			failCount++;
			$error("halted fell without reset");
		end

endmodule

bind cpuTop cpuBusChecker busCheck (
	.clk(clk),
	.rstN(rstN),
	.wbAdr(wbAdr),
	.wbDatOut(wbDatOut),
	.wbWe(wbWe),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAck(wbAck),
	.halted(halted)
);

/* sim/tbCpu.sv */
`timescale 1ns/1ps

module tbCpu import cpuPkg::*; ();

	localparam int numTests = 9;

	logic clk = 1'b0;
	logic rstN = 1'b0;
	addrT wbAdr;
	dataT wbDatOut;
	dataT wbDatIn = '0;
	logic wbWe;
	logic wbCyc;
	logic wbStb;
	logic wbAck = 1'b0;
	logic halted;

	logic [15:0] progLfsr = 16'd50552;
	logic [15:0] waitLfsr = 16'd50552;
	int unsigned waitLeft = 0;
	int errors = 0;
	int checks = 0;
	int pos;
	bit timedOut = 0;
	logic [7:0] img [256];
	logic [7:0] mdl [256];
	logic [7:0] mem [256];
	logic [7:0] expAdr [$];
	logic [7:0] expDat [$];
	logic [7:0] gotAdr [$];
	logic [7:0] gotDat [$];
	logic [7:0] mixOps [16] = '{RSTALL, RSTAC, RSTADDR, INCAC, INCADDR, INCSTP, LDADDR, ADD,
		MADDR, MSTP, MSTPAC, STAC, STAC, STAC, INCAC, LDADDR};

	cpuTop DUT (
		.clk(clk),
		.rstN(rstN),
		.wbAdr(wbAdr),
		.wbDatOut(wbDatOut),
		.wbDatIn(wbDatIn),
		.wbWe(wbWe),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAck(wbAck),
		.halted(halted)
	);

	always #2 clk = ~clk;

	// taps 16,14,13,11
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic drawBits(inout logic [15:0] s, input int n, output int unsigned v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			s = lfsrStep(s);
			v = (v << 1) | s[0];
		end
	endtask

	task automatic checkEq(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[ERROR] %0t: %s got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// memory slave, 0 to 3 wait states per cycle
	always @(posedge clk) begin : slave
		int unsigned r;
		if (!rstN) begin
			wbAck <= 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0;
			drawBits(waitLfsr, 2, r);
			waitLeft <= r;
		end else if (wbCyc && wbStb) begin
			if (waitLeft == 0) begin
				wbAck <= 1'b1;
				if (wbWe) begin
					mem[wbAdr] = wbDatOut;
					gotAdr.push_back(wbAdr);
					gotDat.push_back(wbDatOut);
				end else begin
					wbDatIn <= mem[wbAdr];
				end
			end else begin
				waitLeft <= waitLeft - 1;
			end
		end
	end

	task automatic emit(input logic [7:0] b);
		img[pos[7:0]] = b;
		pos++;
	endtask

	// kind 0 mixed ops, 1 loads, 2 zero jumps
	task automatic genProgram(input int kind);
		int unsigned r;
		int k;
		for (int a = 0; a < 256; a++) begin
			drawBits(progLfsr, 8, r);
			img[a] = r[7:0];
		end
		pos = 0;
		drawBits(progLfsr, 7, r);
		emit(RSTALL);
		emit(LDADDR);
		emit(8'h80 | r[7:0]);
		emit(ADD);
		emit(MSTP);
		while (pos < 96) begin
			if (kind == 0) begin
				drawBits(progLfsr, 4, r);
				emit(mixOps[r]);
				if (mixOps[r] == LDADDR) begin
					drawBits(progLfsr, 8, r);
					emit(r[7:0]);
				end
			end else if (kind == 1) begin
				drawBits(progLfsr, 7, r);
				emit(LDADDR);
				emit(8'h80 | r[7:0]);
				emit(LDAC);
				emit(STAC);
				emit(INCSTP);
				drawBits(progLfsr, 1, r);
				if (r == 1) begin
					emit(ADD);
					emit(STAC);
				end
			end else begin
				drawBits(progLfsr, 1, r);
				emit(RSTAC);
				// INCAC makes the jump fall through
				if (r == 1) begin
					emit(INCAC);
				end
				drawBits(progLfsr, 1, r);
				k = 1 + r;
				emit(JMPZ);
				emit(pos + 1 + k);
				repeat (k) emit(STAC);
				emit(INCSTP);
				emit(STAC);
			end
		end
		emit(ENDOP);
	endtask

	// instruction set model on mdl
	task automatic runModel(output int steps, output bit ended);
		logic [7:0] pc;
		logic [7:0] ac;
		logic [7:0] ad;
		logic [7:0] sp;
		logic [7:0] op;
		pc = 0;
		ac = 0;
		ad = 0;
		sp = 0;
		steps = 0;
		ended = 0;
		expAdr.delete();
		expDat.delete();
		while (!ended && steps < 200) begin
			op = mdl[pc];
			pc = pc + 8'd1;
			steps++;
			case (op)
				ENDOP: ended = 1;
				RSTALL: begin
					ac = 0;
					ad = 0;
					sp = 0;
				end
				RSTAC: ac = 0;
				RSTADDR: ad = 0;
				INCAC: ac = ac + 8'd1;
				INCADDR: ad = ad + 8'd1;
				INCSTP: sp = sp + 8'd1;
				LDADDR: begin
					ad = mdl[pc];
					pc = pc + 8'd1;
				end
				LDAC: ac = mdl[ad];
				ADD: ac = ac + ad;
				MADDR: ad = ac;
				MSTP: sp = ac;
				MSTPAC: ac = sp;
				STAC: begin
					mdl[sp] = ac;
					expAdr.push_back(sp);
					expDat.push_back(ac);
				end
				JMPZ: pc = (ac == 0) ? mdl[pc] : pc + 8'd1;
				default: ;
			endcase
		end
	endtask

	initial begin : main
		int steps;
		bit ended;
		bit seen;
		int errsBefore;
		int busyCnt;
		int n;
		for (int t = 0; t < numTests && !timedOut; t++) begin
			ended = 0;
			for (int tries = 0; tries < 20 && !ended; tries++) begin
				genProgram(t % 3);
				mdl = img;
				runModel(steps, ended);
			end
			if (!ended) begin
				$display("test %0d: no program finished within 200 instructions", t);
				errors++;
				continue;
			end
			errsBefore = errors;
			@(posedge clk);
			rstN <= 1'b0;
			mem = img;
			repeat (3) @(posedge clk);
			rstN <= 1'b1;
			@(negedge clk);
			gotAdr.delete();
			gotDat.delete();
			checkEq(wbCyc, 0, "wbCyc after reset");
			checkEq(wbStb, 0, "wbStb after reset");
			checkEq(halted, 0, "halted after reset");
			seen = 0;
			for (n = 0; n < 20 && !seen; n++) begin
				@(negedge clk);
				seen = wbCyc;
			end
			if (!seen) begin
				$display("test %0d: the first bus cycle never started", t);
				errors++;
				timedOut = 1;
				break;
			end
			checkEq(wbAdr, 0, "first fetch address");
			checkEq(wbWe, 0, "first cycle write enable");
			seen = 0;
			for (n = 0; n < 10000 && !seen; n++) begin
				@(negedge clk);
				seen = halted;
			end
			if (!seen) begin
				$display("test %0d: the program did not reach its end in time", t);
				errors++;
				timedOut = 1;
				break;
			end
			busyCnt = 0;
			repeat (50) begin
				@(negedge clk);
				if (wbCyc) begin
					busyCnt++;
				end
			end
			checkEq(busyCnt, 0, "bus cycles after halt");
			checkEq(gotAdr.size(), expAdr.size(), "store count");
			n = (gotAdr.size() < expAdr.size()) ? gotAdr.size() : expAdr.size();
			for (int i = 0; i < n; i++) begin
				checkEq(gotAdr[i], expAdr[i], $sformatf("store %0d address", i));
				checkEq(gotDat[i], expDat[i], $sformatf("store %0d data", i));
			end
			for (int a = 0; a < 256; a++) begin
				checkEq(mem[a], mdl[a], $sformatf("memory at %0h", a));
			end
			$display("test %0d kind %0d: %0d instructions, %0d stores, %s", t, t % 3, steps,
				expAdr.size(), (errors == errsBefore) ? "ok" : "mismatch");
		end
		errors += DUT.busCheck.failCount;
		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d", numTests, checks,
			errors, DUT.busCheck.failCount);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
